// ==== dv/frontend_input.txt ====
# inst_1 inst_2 inst_en_1 inst_en_2 stall pause update_en branch_flush pc_dispatch taken_actual target_actual
# all hex, one row per cycle; an instruction of 00000000 becomes a random non-branch word
# sequential fetch after reset
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
# branch opcode range and its neighbours
48000000 4c000000 1 1 0 0 0 0 00000000 0 00000000
50000000 54000000 1 1 0 0 0 0 00000000 0 00000000
58000000 5c000000 1 1 0 0 0 0 00000000 0 00000000
60000000 64000000 1 1 0 0 0 0 00000000 0 00000000
68000000 6c000000 1 1 0 0 0 0 00000000 0 00000000
44000000 70000000 1 1 0 0 0 0 00000000 0 00000000
48000000 6c000000 0 0 0 0 0 0 00000000 0 00000000
# train 1c000100 taken to 1c000200, then fetch it in slot 1
00000000 00000000 1 1 0 0 1 0 1c000100 1 1c000200
00000000 00000000 1 1 0 0 1 0 1c000100 1 1c000200
00000000 00000000 1 1 0 0 0 1 00000000 0 1c000100
4c000000 00000000 1 1 1 0 0 0 00000000 0 00000000
4c000000 00000000 1 1 0 0 0 0 00000000 0 00000000
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
# train 1c000304 taken to 1c000400, then fetch it in slot 2
00000000 00000000 1 1 0 0 1 0 1c000304 1 1c000400
00000000 00000000 1 1 0 0 1 0 1c000304 1 1c000400
00000000 00000000 1 1 0 0 0 1 00000000 0 1c000300
00000000 58000000 1 1 0 0 0 0 00000000 0 00000000
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
# strong counter shared by 1c001100, but its btb tag misses
00000000 00000000 1 1 0 0 0 1 00000000 0 1c001100
4c000000 00000000 1 1 0 0 0 0 00000000 0 00000000
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
# two not-taken updates, then fetch 1c000100 again
00000000 00000000 1 1 0 0 1 0 1c000100 0 00000000
00000000 00000000 1 1 0 0 1 0 1c000100 0 00000000
00000000 00000000 1 1 0 0 0 1 00000000 0 1c000100
4c000000 00000000 1 1 0 0 0 0 00000000 0 00000000
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
# stall, pause, flush during stall
00000000 00000000 1 1 1 0 0 0 00000000 0 00000000
00000000 00000000 1 1 1 0 0 0 00000000 0 00000000
00000000 00000000 1 1 0 1 0 0 00000000 0 00000000
00000000 00000000 1 1 1 0 0 1 00000000 0 1c000800
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
# misaligned flush target, then back to an aligned one
00000000 00000000 1 1 0 0 0 1 00000000 0 1c000502
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
00000000 00000000 1 1 0 0 0 1 00000000 0 1c000600
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000
00000000 00000000 1 1 0 0 0 0 00000000 0 00000000

// ==== dv/frontend_tb.sv ====
module frontend_tb
    import frontend_pkg::*;
();

    localparam int    BHT_DEPTH    = 64;
    localparam int    BTB_DEPTH    = 16;
    localparam addr_t RESET_PC     = 32'h1c00_0000;
    localparam int    BHT_IDX_W    = $clog2(BHT_DEPTH);
    localparam int    BTB_IDX_W    = $clog2(BTB_DEPTH);
    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 10;

    // one stimulus row, columns as in the input file
    typedef struct packed {
        inst_t inst_1;
        inst_t inst_2;
        logic  inst_en_1;
        logic  inst_en_2;
        logic  stall;
        logic  pause;
        logic  update_en;
        logic  branch_flush;
        addr_t pc_dispatch;
        logic  taken_actual;
        addr_t target_actual;
    } row_t;

    logic   clk;
    logic   rst;
    logic   stall;
    logic   pause;
    inst_t  inst_1;
    inst_t  inst_2;
    logic   inst_en_1;
    logic   inst_en_2;
    logic   update_en;
    logic   branch_flush;
    addr_t  pc_dispatch;
    logic   taken_actual;
    addr_t  target_actual;
    addr_t  fetch_pc;
    logic   is_branch_1;
    logic   is_branch_2;
    logic   pre_taken_or_not;
    addr_t  pre_branch_addr;
    logic   fetch_inst_1_en;
    logic   fetch_inst_2_en;
    logic   is_exception;
    ecode_t exception_cause;

    row_t rows [$];
    bit   rows_loaded;
    int   seed;
    int   error_count;

    // shadow state of the front end
    counter_t m_bht    [BHT_DEPTH];
    logic     m_valid  [BTB_DEPTH];
    addr_t    m_tag    [BTB_DEPTH];
    addr_t    m_target [BTB_DEPTH];
    addr_t    m_pc;
    logic     m_exc;
    ecode_t   m_cause;

    // expected combinational outputs for the current row
    logic  exp_taken;
    logic  exp_en_1;
    logic  exp_en_2;
    logic  exp_redirect;
    addr_t exp_target;

    frontend_top #(
        .BHT_DEPTH (BHT_DEPTH),
        .BTB_DEPTH (BTB_DEPTH),
        .RESET_PC  (RESET_PC)
    ) u_dut (
        .clk              (clk),
        .rst              (rst),
        .stall            (stall),
        .pause            (pause),
        .inst_1           (inst_1),
        .inst_2           (inst_2),
        .inst_en_1        (inst_en_1),
        .inst_en_2        (inst_en_2),
        .update_en        (update_en),
        .branch_flush     (branch_flush),
        .pc_dispatch      (pc_dispatch),
        .taken_actual     (taken_actual),
        .target_actual    (target_actual),
        .fetch_pc         (fetch_pc),
        .is_branch_1      (is_branch_1),
        .is_branch_2      (is_branch_2),
        .pre_taken_or_not (pre_taken_or_not),
        .pre_branch_addr  (pre_branch_addr),
        .fetch_inst_1_en  (fetch_inst_1_en),
        .fetch_inst_2_en  (fetch_inst_2_en),
        .is_exception     (is_exception),
        .exception_cause  (exception_cause)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_addr(string what, addr_t got, addr_t exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_counter_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_cause(string what, ecode_t got, ecode_t exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic decodes_branch(inst_t inst);
        opcode_t op;
        op = inst[31:26];
        return (op >= BRANCH_OP_LO) && (op <= BRANCH_OP_HI);
    endfunction

    function automatic int bht_index(addr_t pc);
        return int'(pc[BHT_IDX_W+1:2]);
    endfunction

    function automatic int btb_index(addr_t pc);
        return int'(pc[BTB_IDX_W+1:2]);
    endfunction

    function automatic addr_t btb_tag(addr_t pc);
        return pc >> (BTB_IDX_W + 2);
    endfunction

    function automatic logic predicts_taken(inst_t inst, logic en, addr_t pc);
        logic hit;
        hit = m_valid[btb_index(pc)] && (m_tag[btb_index(pc)] == btb_tag(pc));
        return decodes_branch(inst) && en && (m_bht[bht_index(pc)] >= 2'd2) && hit;
    endfunction

    // filler words for rows that leave the instruction open
    function automatic inst_t random_non_branch();
        inst_t inst;
        inst = $random(seed);
        // every branch opcode has bit 31 clear
        if (decodes_branch(inst)) begin
            inst[31] = 1'b1;
        end
        return inst;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < BHT_DEPTH; i++) begin
            m_bht[i] = CNT_RESET;
        end
        for (int i = 0; i < BTB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        m_pc    = RESET_PC;
        m_exc   = 1'b0;
        m_cause = 1'b0;
    endtask

    task automatic compute_expected();
        logic taken_1;
        logic taken_2;
        taken_1 = predicts_taken(inst_1, inst_en_1, m_pc);
        taken_2 = predicts_taken(inst_2, inst_en_2, m_pc + 32'd4);
        exp_taken    = taken_1 || taken_2;
        exp_en_1     = 1'b0;
        exp_en_2     = 1'b0;
        exp_redirect = 1'b0;
        exp_target   = '0;
        if (!(branch_flush || stall || pause)) begin
            exp_en_1 = 1'b1;
            exp_en_2 = !taken_1;
            if (taken_1) begin
                exp_redirect = 1'b1;
                exp_target   = m_target[btb_index(m_pc)];
            end else if (taken_2) begin
                exp_redirect = 1'b1;
                exp_target   = m_target[btb_index(m_pc + 32'd4)];
            end
        end
    endtask

    // state change at the rising edge
    task automatic advance_model();
        int bi;
        int ti;
        m_exc   = (m_pc[1:0] != 2'b00);
        m_cause = ecode_t'(m_exc);
        if (update_en) begin
            bi = bht_index(pc_dispatch);
            if (taken_actual) begin
                if (m_bht[bi] != 2'b11) begin
                    m_bht[bi] = m_bht[bi] + 2'd1;
                end
                ti           = btb_index(pc_dispatch);
                m_valid[ti]  = 1'b1;
                m_tag[ti]    = btb_tag(pc_dispatch);
                m_target[ti] = target_actual;
            end else if (m_bht[bi] != 2'b00) begin
                m_bht[bi] = m_bht[bi] - 2'd1;
            end
        end
        if (branch_flush) begin
            m_pc = target_actual;
        end else if (!(stall || pause)) begin
            if (exp_redirect) begin
                m_pc = exp_target;
            end else begin
                m_pc = m_pc + 32'd8;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic load_rows();
        int    fd;
        int    n;
        string line;
        inst_t i1;
        inst_t i2;
        logic  e1;
        logic  e2;
        logic  st;
        logic  pa;
        logic  ue;
        logic  fl;
        addr_t pd;
        logic  ta;
        addr_t tg;
        fd = $fopen("dv/frontend_input.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/frontend_input.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                            i1, i2, e1, e2, st, pa, ue, fl, pd, ta, tg);
                if (n != 11) begin
                    $display("malformed stimulus line: %s", line);
                    stop_with_failure();
                end
                rows.push_back('{i1, i2, e1, e2, st, pa, ue, fl, pd, ta, tg});
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_row(row_t r);
        // a zero word asks for a random non-branch
        if (r.inst_1 == '0) begin
            inst_1 = random_non_branch();
        end else begin
            inst_1 = r.inst_1;
        end
        if (r.inst_2 == '0) begin
            inst_2 = random_non_branch();
        end else begin
            inst_2 = r.inst_2;
        end
        inst_en_1     = r.inst_en_1;
        inst_en_2     = r.inst_en_2;
        stall         = r.stall;
        pause         = r.pause;
        update_en     = r.update_en;
        branch_flush  = r.branch_flush;
        pc_dispatch   = r.pc_dispatch;
        taken_actual  = r.taken_actual;
        target_actual = r.target_actual;
    endtask

    task automatic check_outputs(int row);
        string at;
        at = $sformatf("row %0d", row);
        check_addr({at, " fetch_pc"}, fetch_pc, m_pc);
        check_counter_flag({at, " is_branch_1"}, is_branch_1, decodes_branch(inst_1));
        check_counter_flag({at, " is_branch_2"}, is_branch_2, decodes_branch(inst_2));
        check_counter_flag({at, " pre_taken_or_not"}, pre_taken_or_not, exp_taken);
        check_addr({at, " pre_branch_addr"}, pre_branch_addr, exp_target);
        check_counter_flag({at, " fetch_inst_1_en"}, fetch_inst_1_en, exp_en_1);
        check_counter_flag({at, " fetch_inst_2_en"}, fetch_inst_2_en, exp_en_2);
        check_counter_flag({at, " is_exception"}, is_exception, m_exc);
        check_cause({at, " exception_cause"}, exception_cause, m_cause);
    endtask

    // watchdog sized from the row count
    initial begin
        wait (rows_loaded);
        #((rows.size() + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("run timed out before all %0d rows were applied", rows.size());
        stop_with_failure();
    end

    initial begin
        seed          = 32'h5142_fab6;
        error_count   = 0;
        rst           = 1'b1;
        stall         = 1'b0;
        pause         = 1'b0;
        inst_1        = '0;
        inst_2        = '0;
        inst_en_1     = 1'b0;
        inst_en_2     = 1'b0;
        update_en     = 1'b0;
        branch_flush  = 1'b0;
        pc_dispatch   = '0;
        taken_actual  = 1'b0;
        target_actual = '0;
        reset_model();
        load_rows();
        rows_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_addr("fetch_pc in reset", fetch_pc, RESET_PC);
        check_counter_flag("fetch_inst_1_en in reset", fetch_inst_1_en, 1'b0);
        check_counter_flag("fetch_inst_2_en in reset", fetch_inst_2_en, 1'b0);
        check_counter_flag("is_exception in reset", is_exception, 1'b0);
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            #(CLK_PERIOD - 3);
            compute_expected();
            check_outputs(i);
            @(posedge clk);
            advance_model();
            #1;
        end
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module frontend_tb -f sources.f -o frontend_sim

output=$(./obj_dir/frontend_sim 2>&1) || true
echo "$output"

if grep -qx "ALL TESTS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== sources.f ====
src/frontend_pkg.sv
src/branch_update_if.sv
src/bht.sv
src/btb.sv
src/bpu.sv
src/pc_gen.sv
src/frontend_top.sv
dv/frontend_tb.sv

// ==== src/bht.sv ====
module bht
    import frontend_pkg::*;
#(
    parameter int BHT_DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     rst,
    branch_update_if.consumer        upd,
    input  addr_t                    pc_1,
    input  addr_t                    pc_2,
    output counter_t                 counter_1,
    output counter_t                 counter_2
);

    localparam int IDX_W = $clog2(BHT_DEPTH);

    typedef logic [IDX_W-1:0] bht_idx_t;

    counter_t cnt_q [BHT_DEPTH];

    bht_idx_t rd_idx_1;
    bht_idx_t rd_idx_2;
    bht_idx_t upd_idx;
    counter_t cnt_next;

    // word index, low two pc bits dropped
    assign rd_idx_1 = pc_1[IDX_W+1:2];
    assign rd_idx_2 = pc_2[IDX_W+1:2];
    assign upd_idx  = upd.pc_dispatch[IDX_W+1:2];

    // reads see the table before this edge's update
    assign counter_1 = cnt_q[rd_idx_1];
    assign counter_2 = cnt_q[rd_idx_2];

    // one step toward the resolved direction
    always_comb begin
        counter_t cur;
        cur = cnt_q[upd_idx];
        cnt_next = cur;
        if (upd.taken_actual) begin
            if (cur != 2'b11) begin
                cnt_next = cur + 2'd1;
            end
        end else begin
            if (cur != 2'b00) begin
                cnt_next = cur - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_DEPTH; i++) begin
                cnt_q[i] <= CNT_RESET;
            end
        end else if (upd.update_en) begin
            cnt_q[upd_idx] <= cnt_next;
        end
    end

    // an unknown index would corrupt an arbitrary entry
    a_upd_pc_known: assert property (
        @(posedge clk) disable iff (rst)
        upd.update_en |-> !$isunknown(upd.pc_dispatch)
    ) else $error("bht update with unknown pc_dispatch");

endmodule

// ==== src/bpu.sv ====
module bpu
    import frontend_pkg::*;
#(
    parameter int BHT_DEPTH = 64,
    parameter int BTB_DEPTH = 16
) (
    input  logic              clk,
    input  logic              rst,
    branch_update_if.consumer upd,
    input  logic              stall,
    input  logic              pause,
    input  addr_t             fetch_pc,
    input  logic              pc_exception,
    input  ecode_t            pc_ecode,
    input  inst_t             inst_1,
    input  inst_t             inst_2,
    input  logic              inst_en_1,
    input  logic              inst_en_2,
    output logic              is_branch_1,
    output logic              is_branch_2,
    output logic              pre_taken_or_not,
    output logic              redirect_en,
    output addr_t             pre_branch_addr,
    output logic              fetch_inst_1_en,
    output logic              fetch_inst_2_en,
    output logic              is_exception,
    output ecode_t            exception_cause
);

    opcode_t  op_1;
    opcode_t  op_2;
    addr_t    pc_2;
    counter_t counter_1;
    counter_t counter_2;
    logic     hit_1;
    logic     hit_2;
    addr_t    target_1;
    addr_t    target_2;
    logic     taken_1;
    logic     taken_2;
    logic     blocked;

    // second slot sits one word after the first
    assign pc_2 = fetch_pc + 32'd4;

    ////////////////////////////////////////////////////////////
    // decode and per-slot prediction
    ////////////////////////////////////////////////////////////

    assign op_1 = inst_1[31:26];
    assign op_2 = inst_2[31:26];

    // branch opcodes form one contiguous range
    assign is_branch_1 = (op_1 >= BRANCH_OP_LO) && (op_1 <= BRANCH_OP_HI);
    assign is_branch_2 = (op_2 >= BRANCH_OP_LO) && (op_2 <= BRANCH_OP_HI);

    // counter msb set means taken, and a target must be known
    assign taken_1 = is_branch_1 && inst_en_1 && counter_1[1] && hit_1;
    assign taken_2 = is_branch_2 && inst_en_2 && counter_2[1] && hit_2;

    assign pre_taken_or_not = taken_1 || taken_2;

    bht #(
        .BHT_DEPTH (BHT_DEPTH)
    ) u_bht (
        .clk       (clk),
        .rst       (rst),
        .upd       (upd),
        .pc_1      (fetch_pc),
        .pc_2      (pc_2),
        .counter_1 (counter_1),
        .counter_2 (counter_2)
    );

    btb #(
        .BTB_DEPTH (BTB_DEPTH)
    ) u_btb (
        .clk      (clk),
        .rst      (rst),
        .upd      (upd),
        .pc_1     (fetch_pc),
        .pc_2     (pc_2),
        .hit_1    (hit_1),
        .hit_2    (hit_2),
        .target_1 (target_1),
        .target_2 (target_2)
    );

    ////////////////////////////////////////////////////////////
    // slot select and fetch enables
    ////////////////////////////////////////////////////////////

    assign blocked = rst || upd.branch_flush || stall || pause;

    always_comb begin
        fetch_inst_1_en = 1'b0;
        fetch_inst_2_en = 1'b0;
        redirect_en     = 1'b0;
        pre_branch_addr = '0;
        if (!blocked) begin
            if (taken_1) begin
                // slot 2 is on the wrong path
                fetch_inst_1_en = 1'b1;
                redirect_en     = 1'b1;
                pre_branch_addr = target_1;
            end else if (taken_2) begin
                fetch_inst_1_en = 1'b1;
                fetch_inst_2_en = 1'b1;
                redirect_en     = 1'b1;
                pre_branch_addr = target_2;
            end else begin
                fetch_inst_1_en = 1'b1;
                fetch_inst_2_en = 1'b1;
            end
        end
    end

    // exception travels one stage with the fetched pair
    always_ff @(posedge clk) begin
        if (rst) begin
            is_exception    <= 1'b0;
            exception_cause <= '0;
        end else begin
            is_exception    <= pc_exception;
            exception_cause <= pc_ecode;
        end
    end

    a_slot_order: assert property (
        @(posedge clk) disable iff (rst)
        fetch_inst_2_en |-> fetch_inst_1_en
    ) else $error("slot 2 enabled without slot 1");

endmodule

// ==== src/branch_update_if.sv ====
interface branch_update_if
    import frontend_pkg::*;
();

    // resolution info coming back from execute
    logic  update_en;
    logic  branch_flush;
    addr_t pc_dispatch;
    logic  taken_actual;
    addr_t target_actual;

    // execute side
    modport producer (
        output update_en,
        output branch_flush,
        output pc_dispatch,
        output taken_actual,
        output target_actual
    );

    // front end tables and pc
    modport consumer (
        input update_en,
        input branch_flush,
        input pc_dispatch,
        input taken_actual,
        input target_actual
    );

endinterface

// ==== src/btb.sv ====
module btb
    import frontend_pkg::*;
#(
    parameter int BTB_DEPTH = 16
) (
    input  logic              clk,
    input  logic              rst,
    branch_update_if.consumer upd,
    input  addr_t             pc_1,
    input  addr_t             pc_2,
    output logic              hit_1,
    output logic              hit_2,
    output addr_t             target_1,
    output addr_t             target_2
);

    localparam int IDX_W = $clog2(BTB_DEPTH);
    localparam int TAG_W = 32 - IDX_W - 2;

    typedef logic [IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0] btb_tag_t;

    // valid is control state, tag and target are payload
    logic     valid_q  [BTB_DEPTH];
    btb_tag_t tag_q    [BTB_DEPTH];
    addr_t    target_q [BTB_DEPTH];

    btb_idx_t rd_idx_1;
    btb_idx_t rd_idx_2;
    btb_idx_t wr_idx;
    logic     wr_en;

    assign rd_idx_1 = pc_1[IDX_W+1:2];
    assign rd_idx_2 = pc_2[IDX_W+1:2];
    assign wr_idx   = upd.pc_dispatch[IDX_W+1:2];

    // only taken branches are worth a target
    assign wr_en = upd.update_en && upd.taken_actual;

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    assign hit_1    = valid_q[rd_idx_1] && (tag_q[rd_idx_1] == pc_1[31:IDX_W+2]);
    assign hit_2    = valid_q[rd_idx_2] && (tag_q[rd_idx_2] == pc_2[31:IDX_W+2]);
    assign target_1 = target_q[rd_idx_1];
    assign target_2 = target_q[rd_idx_2];

    ////////////////////////////////////////////////////////////
    // fill
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BTB_DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= upd.pc_dispatch[31:IDX_W+2];
            target_q[wr_idx] <= upd.target_actual;
        end
    end

    // a stored target is fetched as-is, so it must be a word address
    a_target_aligned: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (upd.target_actual[1:0] == 2'b00)
    ) else $error("btb written with misaligned target");

endmodule

// ==== src/frontend_pkg.sv ====
package frontend_pkg;

    ////////////////////////////////////////////////////////////
    // basic widths
    ////////////////////////////////////////////////////////////

    // one fetch address, byte granular
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // major opcode field, inst[31:26]
    typedef logic [5:0] opcode_t;

    // bimodal saturating counter
    // 00 strong nt, 01 weak nt, 10 weak t, 11 strong t
    typedef logic [1:0] counter_t;

    // exception cause, 1 means misaligned fetch pc
    typedef logic ecode_t;

    ////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////

    // counters start weakly not taken
    localparam counter_t CNT_RESET = 2'b01;

    // contiguous opcode range of conditional and direct branches
    localparam opcode_t BRANCH_OP_LO = 6'b010010;
    localparam opcode_t BRANCH_OP_HI = 6'b011011;

endpackage

// ==== src/frontend_top.sv ====
module frontend_top
    import frontend_pkg::*;
#(
    parameter int    BHT_DEPTH = 64,
    parameter int    BTB_DEPTH = 16,
    parameter addr_t RESET_PC  = 32'h1c00_0000
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   stall,
    input  logic   pause,
    input  inst_t  inst_1,
    input  inst_t  inst_2,
    input  logic   inst_en_1,
    input  logic   inst_en_2,
    input  logic   update_en,
    input  logic   branch_flush,
    input  addr_t  pc_dispatch,
    input  logic   taken_actual,
    input  addr_t  target_actual,
    output addr_t  fetch_pc,
    output logic   is_branch_1,
    output logic   is_branch_2,
    output logic   pre_taken_or_not,
    output addr_t  pre_branch_addr,
    output logic   fetch_inst_1_en,
    output logic   fetch_inst_2_en,
    output logic   is_exception,
    output ecode_t exception_cause
);

    logic   redirect_en;
    logic   pc_exception;
    ecode_t pc_ecode;

    branch_update_if u_upd ();

    // execute-side resolution enters here
    assign u_upd.update_en     = update_en;
    assign u_upd.branch_flush  = branch_flush;
    assign u_upd.pc_dispatch   = pc_dispatch;
    assign u_upd.taken_actual  = taken_actual;
    assign u_upd.target_actual = target_actual;

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk             (clk),
        .rst             (rst),
        .upd             (u_upd.consumer),
        .stall           (stall),
        .pause           (pause),
        .redirect_en     (redirect_en),
        .pre_branch_addr (pre_branch_addr),
        .fetch_pc        (fetch_pc),
        .pc_exception    (pc_exception),
        .pc_ecode        (pc_ecode)
    );

    bpu #(
        .BHT_DEPTH (BHT_DEPTH),
        .BTB_DEPTH (BTB_DEPTH)
    ) u_bpu (
        .clk              (clk),
        .rst              (rst),
        .upd              (u_upd.consumer),
        .stall            (stall),
        .pause            (pause),
        .fetch_pc         (fetch_pc),
        .pc_exception     (pc_exception),
        .pc_ecode         (pc_ecode),
        .inst_1           (inst_1),
        .inst_2           (inst_2),
        .inst_en_1        (inst_en_1),
        .inst_en_2        (inst_en_2),
        .is_branch_1      (is_branch_1),
        .is_branch_2      (is_branch_2),
        .pre_taken_or_not (pre_taken_or_not),
        .redirect_en      (redirect_en),
        .pre_branch_addr  (pre_branch_addr),
        .fetch_inst_1_en  (fetch_inst_1_en),
        .fetch_inst_2_en  (fetch_inst_2_en),
        .is_exception     (is_exception),
        .exception_cause  (exception_cause)
    );

endmodule

// ==== src/pc_gen.sv ====
module pc_gen
    import frontend_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h1c00_0000
) (
    input  logic              clk,
    input  logic              rst,
    branch_update_if.consumer upd,
    input  logic              stall,
    input  logic              pause,
    input  logic              redirect_en,
    input  addr_t             pre_branch_addr,
    output addr_t             fetch_pc,
    output logic              pc_exception,
    output ecode_t            pc_ecode
);

    logic hold;

    assign hold = stall || pause;

    ////////////////////////////////////////////////////////////
    // fetch pc
    ////////////////////////////////////////////////////////////

    // flush beats hold, hold beats prediction
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= RESET_PC;
        end else if (upd.branch_flush) begin
            fetch_pc <= upd.target_actual;
        end else if (hold) begin
            fetch_pc <= fetch_pc;
        end else if (redirect_en) begin
            fetch_pc <= pre_branch_addr;
        end else begin
            // two words per fetch
            fetch_pc <= fetch_pc + 32'd8;
        end
    end

    // misaligned fetch, usually from a bad flush target
    assign pc_exception = (fetch_pc[1:0] != 2'b00);
    assign pc_ecode     = pc_exception ? ecode_t'(1'b1) : ecode_t'(1'b0);

    a_hold_pc: assert property (
        @(posedge clk) disable iff (rst)
        (hold && !upd.branch_flush) |=> $stable(fetch_pc)
    ) else $error("fetch_pc moved while held");

endmodule
